// ==== design/simd_pkg.sv ====
// vector unit package with widths, instruction format and operation encodings
`default_nettype none

package simd_pkg;

	// ============================
	// configuration defaults
	// ============================
	// lanes per vector
	localparam int VSIZE = 4;
	// bits per lane
	localparam int DBW = 16;
	// entries in the program table
	localparam int N_INST = 8;
	// fixed storage sizes
	localparam int NREG = 8;
	localparam int TBUF_SIZE = 2;
	localparam int ISA_BW = 21;
	localparam int PC_BW = $clog2(N_INST);

	// ============================
	// field types
	// ============================
	typedef logic [2:0] reg_addr_t;
	typedef logic [3:0] shamt_t;
	typedef logic [PC_BW-1:0] pc_t;

	// lane-wise operations
	typedef enum logic [2:0] {
		OP_ADD, OP_SUB, OP_MUL, OP_SRA, OP_MAX, OP_PASS
	} opcode_e;

	// where an operand comes from
	typedef enum logic [1:0] {
		SRC_REG, SRC_SRAM, SRC_TMP, SRC_CONST
	} src_e;

	// instruction word, msb first, ISA_BW bits in total
	typedef struct packed {
		opcode_e   opcode;
		src_e      sel_a;
		src_e      sel_b;
		shamt_t    shamt;
		reg_addr_t raddr;
		reg_addr_t waddr;
		logic      to_reg;
		logic      to_dram;
		logic      to_temp;
		logic      last;
	} inst_t;

endpackage

`default_nettype wire

// ==== design/simd_op_if.sv ====
// decoded instruction bundle from the operand stage to the arithmetic stage
`timescale 1ns/10ps
`default_nettype none

interface simd_op_if #(
	parameter int VSIZE = simd_pkg::VSIZE,
	parameter int DBW = simd_pkg::DBW
);
	import simd_pkg::*;

	// rdy from the operand stage, ack from the alu on retire
	logic      rdy;
	logic      ack;
	// decoded fields, held while rdy is high
	opcode_e   opcode;
	src_e      sel_a;
	src_e      sel_b;
	shamt_t    shamt;
	reg_addr_t waddr;
	logic      to_reg;
	logic      to_dram;
	logic      to_temp;
	logic      last;
	// register read data for raddr
	logic [DBW-1:0] rdata [VSIZE];

	modport operand (
		output rdy, opcode, sel_a, sel_b, shamt, waddr,
		output to_reg, to_dram, to_temp, last, rdata,
		input  ack
	);

	modport alu (
		input  rdy, opcode, sel_a, sel_b, shamt, waddr,
		input  to_reg, to_dram, to_temp, last, rdata,
		output ack
	);

endinterface

`default_nettype wire

// ==== design/simd_operand.sv ====
// operand stage that walks the program, decodes and issues the register read
`timescale 1ns/10ps
`default_nettype none

module simd_operand #(
	parameter int VSIZE = simd_pkg::VSIZE,
	parameter int DBW = simd_pkg::DBW,
	parameter int N_INST = simd_pkg::N_INST
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	// program start
	input  logic               i_inst_rdy,
	output logic               o_inst_ack,
	input  simd_pkg::pc_t      i_pc,
	input  simd_pkg::inst_t    i_insts [N_INST],
	// register read port
	output logic               o_reg_re,
	output simd_pkg::reg_addr_t o_reg_raddr,
	input  logic [DBW-1:0]     i_reg_rdata [VSIZE],
	// to the alu
	simd_op_if.operand         op
);
	import simd_pkg::*;

	// ============================
	// state
	// ============================
	typedef enum logic [1:0] {
		IDLE, READ, OFFER
	} state_e;

	state_e state_r;
	pc_t    pc_r;
	// decoded instruction, loaded in READ
	inst_t  inst_r;

	// ============================
	// control
	// ============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= IDLE;
			pc_r <= '0;
		end else begin
			case (state_r)
				IDLE: begin
					// program start accepted
					if (i_inst_rdy) begin
						pc_r <= i_pc;
						state_r <= READ;
					end
				end
				READ: begin
					state_r <= OFFER;
				end
				OFFER: begin
					if (op.ack) begin
						// last instruction ends the program
						if (inst_r.last) begin
							state_r <= IDLE;
						end else begin
							pc_r <= pc_r + 1'b1;
							state_r <= READ;
						end
					end
				end
				default: state_r <= IDLE;
			endcase
		end
	end

	// latch the word at pc while the register read is in progress
	always_ff @(posedge i_clk) begin
		if (state_r == READ) begin
			inst_r <= i_insts[pc_r];
		end
	end

	always_comb begin
		o_inst_ack = (state_r == IDLE) && i_inst_rdy;
		// raddr is taken straight from the table
		o_reg_re = (state_r == READ);
		o_reg_raddr = i_insts[pc_r].raddr;
		op.rdy = (state_r == OFFER);
	end

	// ============================
	// op bundle
	// ============================
	always_comb begin
		op.opcode = inst_r.opcode;
		op.sel_a = inst_r.sel_a;
		op.sel_b = inst_r.sel_b;
		op.shamt = inst_r.shamt;
		op.waddr = inst_r.waddr;
		op.to_reg = inst_r.to_reg;
		op.to_dram = inst_r.to_dram;
		op.to_temp = inst_r.to_temp;
		op.last = inst_r.last;
		// register output holds until the next read enable
		op.rdata = i_reg_rdata;
	end

endmodule

`default_nettype wire

// ==== design/simd_alu.sv ====
// arithmetic stage that gathers operands, computes lanes and retires results
`timescale 1ns/10ps
`default_nettype none

module simd_alu #(
	parameter int VSIZE = simd_pkg::VSIZE,
	parameter int DBW = simd_pkg::DBW
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	simd_op_if.alu              op,
	input  logic [DBW-1:0]      i_const,
	// sram read stream
	input  logic                i_sramrd_rdy,
	output logic                o_sramrd_ack,
	input  logic [DBW-1:0]      i_sramrd [VSIZE],
	// dram write stream
	output logic                o_dramwd_rdy,
	input  logic                i_dramwd_ack,
	output logic [DBW-1:0]      o_dramwd [VSIZE],
	// register and temp buffer writes
	output logic                o_reg_we,
	output simd_pkg::reg_addr_t o_reg_waddr,
	output logic [DBW-1:0]      o_wdata [VSIZE],
	output logic                o_tbuf_we,
	input  logic [DBW-1:0]      i_tbuf_rdatas [simd_pkg::TBUF_SIZE][VSIZE],
	output logic                o_inst_commit
);
	import simd_pkg::*;

	typedef logic [DBW-1:0] lane_t;

	typedef enum logic [1:0] {
		IDLE, FETCH_SRAM, COMPUTE, DRAIN
	} state_e;

	state_e state_r;
	lane_t  sram_r [VSIZE];
	lane_t  result_r [VSIZE];
	lane_t  lane_res [VSIZE];
	logic   need_sram;
	logic   sram_xfer;
	logic   retire;

	// ============================
	// lane functions
	// ============================
	function automatic lane_t pick_src(src_e sel, lane_t r, lane_t s, lane_t t, lane_t c);
		case (sel)
			SRC_REG:  return r;
			SRC_SRAM: return s;
			SRC_TMP:  return t;
			default:  return c;
		endcase
	endfunction

	// all arithmetic wraps at DBW bits
	function automatic lane_t lane_op(opcode_e opc, lane_t a, lane_t b, shamt_t sh);
		case (opc)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			// low half of the product
			OP_MUL:  return a * b;
			OP_SRA:  return $signed(a) >>> sh;
			OP_MAX:  return ($signed(a) > $signed(b)) ? a : b;
			default: return a;
		endcase
	endfunction

	// ============================
	// handshakes
	// ============================
	always_comb begin
		need_sram = (op.sel_a == SRC_SRAM) || (op.sel_b == SRC_SRAM);
		// one sram vector per instruction
		o_sramrd_ack = (state_r == FETCH_SRAM) && i_sramrd_rdy;
		sram_xfer = o_sramrd_ack;
		o_dramwd_rdy = (state_r == DRAIN) && op.to_dram;
		// a pending dram write holds the retire
		retire = (state_r == DRAIN) && (!op.to_dram || i_dramwd_ack);
		op.ack = retire;
		o_reg_we = retire && op.to_reg;
		o_tbuf_we = retire && op.to_temp;
		o_inst_commit = retire && op.last;
		o_reg_waddr = op.waddr;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= IDLE;
		end else begin
			case (state_r)
				IDLE: begin
					if (op.rdy) begin
						state_r <= need_sram ? FETCH_SRAM : COMPUTE;
					end
				end
				FETCH_SRAM: begin
					if (sram_xfer) begin
						state_r <= COMPUTE;
					end
				end
				COMPUTE: state_r <= DRAIN;
				DRAIN: begin
					if (retire) begin
						state_r <= IDLE;
					end
				end
				default: state_r <= IDLE;
			endcase
		end
	end

	// ============================
	// datapath
	// ============================
	// tmp slot 0 feeds a, slot 1 feeds b
	always_comb begin
		for (int i = 0; i < VSIZE; i++) begin
			lane_res[i] = lane_op(
				op.opcode,
				pick_src(op.sel_a, op.rdata[i], sram_r[i], i_tbuf_rdatas[0][i], i_const),
				pick_src(op.sel_b, op.rdata[i], sram_r[i], i_tbuf_rdatas[1][i], i_const),
				op.shamt
			);
		end
	end

	always_ff @(posedge i_clk) begin
		if (sram_xfer) begin
			sram_r <= i_sramrd;
		end
		if (state_r == COMPUTE) begin
			result_r <= lane_res;
		end
	end

	// result goes out on every destination
	assign o_dramwd = result_r;
	assign o_wdata = result_r;

endmodule

`default_nettype wire

// ==== design/simd_register.sv ====
// vector register file with one synchronous read port and one write port
`timescale 1ns/10ps
`default_nettype none

module simd_register #(
	parameter int VSIZE = simd_pkg::VSIZE,
	parameter int DBW = simd_pkg::DBW
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	// write port
	input  logic                  i_we,
	input  simd_pkg::reg_addr_t   i_waddr,
	input  logic [VSIZE*DBW-1:0]  i_wdata,
	// read port
	input  logic                  i_re,
	input  simd_pkg::reg_addr_t   i_raddr,
	output logic [VSIZE*DBW-1:0]  o_rdata
);
	import simd_pkg::*;

	typedef logic [VSIZE*DBW-1:0] flat_t;

	// one flat word per register
	flat_t mem_r [NREG];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NREG; i++) begin
				mem_r[i] <= '0;
			end
			o_rdata <= '0;
		end else begin
			if (i_we) begin
				mem_r[i_waddr] <= i_wdata;
			end
			// read data holds while i_re is low
			if (i_re) begin
				o_rdata <= mem_r[i_raddr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/simd_tmp_buffer.sv ====
// shift buffer of the most recent results for read back by the alu
`timescale 1ns/10ps
`default_nettype none

module simd_tmp_buffer #(
	parameter int VSIZE = simd_pkg::VSIZE,
	parameter int DBW = simd_pkg::DBW
) (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_we,
	input  logic [DBW-1:0] i_wdata [VSIZE],
	// slot 0 is the newest entry
	output logic [DBW-1:0] o_rdatas [simd_pkg::TBUF_SIZE][VSIZE]
);
	import simd_pkg::*;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int s = 0; s < TBUF_SIZE; s++) begin
				for (int i = 0; i < VSIZE; i++) begin
					o_rdatas[s][i] <= '0;
				end
			end
		end else if (i_we) begin
			// older slots move down by one
			for (int s = TBUF_SIZE-1; s > 0; s--) begin
				o_rdatas[s] <= o_rdatas[s-1];
			end
			o_rdatas[0] <= i_wdata;
		end
	end

endmodule

`default_nettype wire

// ==== design/simd.sv ====
// vector execution unit top level joining operand, alu, registers and temp buffer
`timescale 1ns/10ps
`default_nettype none

module simd #(
	parameter int VSIZE = simd_pkg::VSIZE,
	parameter int DBW = simd_pkg::DBW,
	parameter int N_INST = simd_pkg::N_INST
) (
	input  logic            i_clk,
	input  logic            i_rst_n,
	// program start
	input  logic            i_inst_rdy,
	output logic            o_inst_ack,
	input  simd_pkg::pc_t   i_pc,
	input  simd_pkg::inst_t i_insts [N_INST],
	input  logic [DBW-1:0]  i_const,
	// sram read stream
	input  logic            i_sramrd_rdy,
	output logic            o_sramrd_ack,
	input  logic [DBW-1:0]  i_sramrd [VSIZE],
	// dram write stream
	output logic            o_dramwd_rdy,
	input  logic            i_dramwd_ack,
	output logic [DBW-1:0]  o_dramwd [VSIZE],
	output logic            o_inst_commit
);
	import simd_pkg::*;

	// ============================
	// internal wiring
	// ============================
	// operand to register file
	logic                 reg_re;
	reg_addr_t            reg_raddr;
	logic [VSIZE*DBW-1:0] reg_rdata_flat;
	logic [DBW-1:0]       reg_rdata [VSIZE];
	// alu to register file and temp buffer
	logic                 reg_we;
	reg_addr_t            reg_waddr;
	logic [DBW-1:0]       wdata [VSIZE];
	logic [VSIZE*DBW-1:0] wdata_flat;
	logic                 tbuf_we;
	logic [DBW-1:0]       tbuf_rdatas [TBUF_SIZE][VSIZE];

	simd_op_if #(.VSIZE(VSIZE), .DBW(DBW)) op_if ();

	// ============================
	// blocks
	// ============================
	simd_operand #(.VSIZE(VSIZE), .DBW(DBW), .N_INST(N_INST)) u_operand (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_inst_rdy(i_inst_rdy), .o_inst_ack(o_inst_ack),
		.i_pc(i_pc), .i_insts(i_insts),
		.o_reg_re(reg_re), .o_reg_raddr(reg_raddr), .i_reg_rdata(reg_rdata),
		.op(op_if.operand)
	);

	simd_alu #(.VSIZE(VSIZE), .DBW(DBW)) u_alu (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.op(op_if.alu), .i_const(i_const),
		.i_sramrd_rdy(i_sramrd_rdy), .o_sramrd_ack(o_sramrd_ack), .i_sramrd(i_sramrd),
		.o_dramwd_rdy(o_dramwd_rdy), .i_dramwd_ack(i_dramwd_ack), .o_dramwd(o_dramwd),
		.o_reg_we(reg_we), .o_reg_waddr(reg_waddr), .o_wdata(wdata),
		.o_tbuf_we(tbuf_we), .i_tbuf_rdatas(tbuf_rdatas),
		.o_inst_commit(o_inst_commit)
	);

	simd_register #(.VSIZE(VSIZE), .DBW(DBW)) u_register (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_we(reg_we), .i_waddr(reg_waddr), .i_wdata(wdata_flat),
		.i_re(reg_re), .i_raddr(reg_raddr), .o_rdata(reg_rdata_flat)
	);

	// temp buffer shares the alu write data with the register file
	simd_tmp_buffer #(.VSIZE(VSIZE), .DBW(DBW)) u_tbuf (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_we(tbuf_we), .i_wdata(wdata), .o_rdatas(tbuf_rdatas)
	);

	// lane i sits at bits [(i+1)*DBW-1 -: DBW] of the flat word
	always_comb begin
		for (int i = 0; i < VSIZE; i++) begin
			reg_rdata[i] = reg_rdata_flat[(i+1)*DBW-1 -: DBW];
			wdata_flat[(i+1)*DBW-1 -: DBW] = wdata[i];
		end
	end

endmodule

`default_nettype wire

// ==== sim/simd_checker.sv ====
// DRAM write stream and commit checker for the vector execution unit testbench
`timescale 1ns/10ps
`default_nettype none

module simd_checker #(
	parameter int VSIZE = 4,
	parameter int DBW = 16
) (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_dramwd_rdy,
	input  logic           i_dramwd_ack,
	input  logic [DBW-1:0] i_dramwd [VSIZE],
	input  logic           i_inst_commit
);
	// expected vectors in arrival order with lane 0 in the low bits
	logic [VSIZE*DBW-1:0] exp_q [$];
	string                name_q [$];
	logic [VSIZE*DBW-1:0] act_v;
	logic [VSIZE*DBW-1:0] exp_v;
	string                name_v;
	int                   mismatches = 0;
	int                   misc_errors = 0;
	int                   commits = 0;

	task automatic push_expected(input string name, input logic [VSIZE*DBW-1:0] vec);
		name_q.push_back(name);
		exp_q.push_back(vec);
	endtask

	// ============================
	// per cycle compare
	// ============================
	always @(posedge i_clk) begin
		if (i_rst_n) begin
			if (i_inst_commit) begin
				commits++;
			end
			// a DRAM write is accepted when rdy and ack are both high
			if (i_dramwd_rdy && i_dramwd_ack) begin
				for (int i = 0; i < VSIZE; i++) begin
					act_v[i*DBW +: DBW] = i_dramwd[i];
				end
				if (exp_q.size() == 0) begin
					$display("extra DRAM write of %h when no write was expected", act_v);
					misc_errors++;
				end else begin
					exp_v = exp_q.pop_front();
					name_v = name_q.pop_front();
					if (act_v !== exp_v) begin
						$display("Mismatch %s expected %h actual %h", name_v, exp_v, act_v);
						mismatches++;
					end
				end
			end
		end
	end

	// leftover expected writes and commit count at the end of the run
	task automatic final_checks(input int programs);
		if (exp_q.size() != 0) begin
			$display("%0d expected DRAM writes never arrived", exp_q.size());
			misc_errors++;
		end
		if (commits != programs) begin
			$display("saw %0d commit pulses for %0d programs", commits, programs);
			misc_errors++;
		end
	endtask

endmodule

`default_nettype wire

// ==== sim/simd_tb.sv ====
// testbench for the vector execution unit running a table of short programs
`timescale 1ns/10ps
`default_nettype none

module simd_tb;
	import simd_pkg::*;

	localparam int NCASE = 4;
	localparam int TIMEOUT = 200;
	localparam int VW = VSIZE*DBW;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic inst_rdy = 1'b0;
	logic inst_ack;
	pc_t pc = '0;
	inst_t insts [N_INST];
	logic [DBW-1:0] cnst = '0;
	logic sramrd_rdy = 1'b0;
	logic sramrd_ack;
	logic [DBW-1:0] sramrd [VSIZE];
	logic dramwd_rdy;
	logic dramwd_ack = 1'b0;
	logic [DBW-1:0] dramwd [VSIZE];
	logic inst_commit;
	int tb_errors = 0;
	int dram_wait = 0;

	// case table
	string case_name [NCASE];
	inst_t prog [NCASE][N_INST];
	pc_t case_pc [NCASE];
	logic [DBW-1:0] case_const [NCASE];
	logic [VW-1:0] sram_vec [NCASE][3];
	int n_sram [NCASE];
	logic [VW-1:0] exp_vec [NCASE][4];
	int n_exp [NCASE];

	simd dut_i (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_inst_rdy(inst_rdy), .o_inst_ack(inst_ack), .i_pc(pc), .i_insts(insts),
		.i_const(cnst),
		.i_sramrd_rdy(sramrd_rdy), .o_sramrd_ack(sramrd_ack), .i_sramrd(sramrd),
		.o_dramwd_rdy(dramwd_rdy), .i_dramwd_ack(dramwd_ack), .o_dramwd(dramwd),
		.o_inst_commit(inst_commit)
	);

	simd_checker #(.VSIZE(VSIZE), .DBW(DBW)) chk_i (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_dramwd_rdy(dramwd_rdy), .i_dramwd_ack(dramwd_ack), .i_dramwd(dramwd),
		.i_inst_commit(inst_commit)
	);

	always #50 clk = ~clk;

	function automatic inst_t make_inst(opcode_e opc, src_e a, src_e b, shamt_t sh,
			reg_addr_t ra, reg_addr_t wa, logic rg, logic dr, logic tp, logic lst);
		inst_t w;
		w.opcode = opc;
		w.sel_a = a;
		w.sel_b = b;
		w.shamt = sh;
		w.raddr = ra;
		w.waddr = wa;
		w.to_reg = rg;
		w.to_dram = dr;
		w.to_temp = tp;
		w.last = lst;
		return w;
	endfunction

	// ============================
	// stimulus table
	// ============================
	task automatic build_cases();
		for (int c = 0; c < NCASE; c++) begin
			for (int k = 0; k < N_INST; k++) begin
				prog[c][k] = make_inst(OP_PASS, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 0, 0, 1);
			end
		end
		// unwritten r5 reads zero, then add and sub with wrap
		case_name[0] = "add_sub_wrap";
		case_pc[0] = 0;
		case_const[0] = 16'h0000;
		prog[0][0] = make_inst(OP_PASS, SRC_REG, SRC_REG, 0, 5, 0, 0, 1, 0, 0);
		prog[0][1] = make_inst(OP_PASS, SRC_SRAM, SRC_SRAM, 0, 0, 1, 1, 1, 0, 0);
		prog[0][2] = make_inst(OP_ADD, SRC_REG, SRC_SRAM, 0, 1, 2, 1, 1, 0, 0);
		prog[0][3] = make_inst(OP_SUB, SRC_REG, SRC_SRAM, 0, 2, 0, 0, 1, 0, 1);
		n_sram[0] = 3;
		sram_vec[0][0] = 64'hfff0_8000_0001_1234;
		sram_vec[0][1] = 64'h0020_8000_ffff_0001;
		sram_vec[0][2] = 64'h0011_0001_0001_2000;
		n_exp[0] = 4;
		exp_vec[0][0] = 64'h0000_0000_0000_0000;
		exp_vec[0][1] = 64'hfff0_8000_0001_1234;
		exp_vec[0][2] = 64'h0010_0000_0000_1235;
		exp_vec[0][3] = 64'hffff_ffff_ffff_f235;
		// constant is -2 in every lane
		case_name[1] = "mul_sra_max";
		case_pc[1] = 0;
		case_const[1] = 16'hfffe;
		prog[1][0] = make_inst(OP_MUL, SRC_SRAM, SRC_CONST, 0, 0, 0, 0, 1, 0, 0);
		prog[1][1] = make_inst(OP_SRA, SRC_SRAM, SRC_SRAM, 4, 0, 0, 0, 1, 0, 0);
		prog[1][2] = make_inst(OP_MAX, SRC_SRAM, SRC_CONST, 0, 0, 0, 0, 1, 0, 1);
		n_sram[1] = 3;
		sram_vec[1][0] = 64'h4000_0003_fffd_0100;
		sram_vec[1][1] = 64'h8000_7ff0_fff0_0123;
		sram_vec[1][2] = 64'h0005_fffd_ffff_8000;
		n_exp[1] = 3;
		exp_vec[1][0] = 64'h8000_fffa_0006_fe00;
		exp_vec[1][1] = 64'hf800_07ff_ffff_0012;
		exp_vec[1][2] = 64'h0005_fffe_ffff_fffe;
		// slot 0 holds 6 and slot 1 holds 3 before the sub
		case_name[2] = "tmp_chain";
		case_pc[2] = 0;
		case_const[2] = 16'h0003;
		prog[2][0] = make_inst(OP_PASS, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 0, 1, 0);
		prog[2][1] = make_inst(OP_ADD, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 1, 1, 0);
		prog[2][2] = make_inst(OP_SUB, SRC_TMP, SRC_TMP, 0, 0, 0, 0, 1, 0, 1);
		n_sram[2] = 0;
		n_exp[2] = 2;
		exp_vec[2][0] = 64'h0006_0006_0006_0006;
		exp_vec[2][1] = 64'h0003_0003_0003_0003;
		// entries 0, 1 and 4 must never run
		case_name[3] = "start_pc";
		case_pc[3] = 2;
		case_const[3] = 16'h00a5;
		prog[3][0] = make_inst(OP_PASS, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 1, 0, 0);
		prog[3][1] = make_inst(OP_PASS, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 1, 0, 0);
		prog[3][2] = make_inst(OP_PASS, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 1, 0, 0);
		prog[3][3] = make_inst(OP_ADD, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 1, 0, 1);
		prog[3][4] = make_inst(OP_PASS, SRC_CONST, SRC_CONST, 0, 0, 0, 0, 1, 0, 1);
		n_sram[3] = 0;
		n_exp[3] = 2;
		exp_vec[3][0] = 64'h00a5_00a5_00a5_00a5;
		exp_vec[3][1] = 64'h014a_014a_014a_014a;
	endtask

	// ============================
	// stream drivers
	// ============================
	task automatic feed_sram(input int c);
		int t;
		for (int v = 0; v < n_sram[c]; v++) begin
			repeat ($urandom_range(0, 3)) @(negedge clk);
			sramrd_rdy = 1'b1;
			for (int i = 0; i < VSIZE; i++) begin
				sramrd[i] = sram_vec[c][v][i*DBW +: DBW];
			end
			t = 0;
			do begin
				@(posedge clk);
				t++;
			end while (!sramrd_ack && t < TIMEOUT);
			if (!sramrd_ack) begin
				$display("timeout: SRAM vector %0d of %s was never taken", v, case_name[c]);
				tb_errors++;
			end
			@(negedge clk);
			sramrd_rdy = 1'b0;
		end
	endtask

	// DRAM ack after a random wait while rdy is held
	initial begin
		forever begin
			@(negedge clk);
			if (dramwd_ack) begin
				dramwd_ack = 1'b0;
			end else if (dramwd_rdy) begin
				if (dram_wait == 0) begin
					dramwd_ack = 1'b1;
					dram_wait = $urandom_range(0, 3);
				end else begin
					dram_wait--;
				end
			end
		end
	end

	task automatic run_program(input int c);
		int t;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!inst_ack && t < TIMEOUT);
		if (!inst_ack) begin
			$display("timeout: program %s was never accepted", case_name[c]);
			tb_errors++;
		end
		@(negedge clk);
		inst_rdy = 1'b0;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!inst_commit && t < TIMEOUT);
		if (!inst_commit) begin
			$display("timeout: program %s never committed", case_name[c]);
			tb_errors++;
		end
	endtask

	// ============================
	// main sequence
	// ============================
	initial begin
		void'($urandom(32'ha1af));
		for (int i = 0; i < VSIZE; i++) begin
			sramrd[i] = '0;
		end
		for (int k = 0; k < N_INST; k++) begin
			insts[k] = '0;
		end
		build_cases();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (inst_ack || sramrd_ack || dramwd_rdy || inst_commit) begin
			$display("a control output is high after reset");
			tb_errors++;
		end
		for (int c = 0; c < NCASE; c++) begin
			@(negedge clk);
			insts = prog[c];
			pc = case_pc[c];
			cnst = case_const[c];
			for (int e = 0; e < n_exp[c]; e++) begin
				chk_i.push_expected(case_name[c], exp_vec[c][e]);
			end
			inst_rdy = 1'b1;
			fork
				feed_sram(c);
				run_program(c);
			join
			repeat (3) @(negedge clk);
		end
		chk_i.final_checks(NCASE);
		$display("errors: mismatches %0d, stream %0d, testbench %0d",
			chk_i.mismatches, chk_i.misc_errors, tb_errors);
		if (chk_i.mismatches + chk_i.misc_errors + tb_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== simd.f ====
design/simd_pkg.sv
design/simd_op_if.sv
design/simd_operand.sv
design/simd_alu.sv
design/simd_register.sv
design/simd_tmp_buffer.sv
design/simd.sv
sim/simd_checker.sv
sim/simd_tb.sv

// ==== Makefile ====
# Verilator build for the vector execution unit

OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module simd -f simd.f

sim:
	verilator --binary --timing -j 0 --top-module simd_tb -f simd.f \
		--Mdir $(OBJ) -o simd_tb
	out="$$(./$(OBJ)/simd_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ)
